//--- hw/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    // ALU operations
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SHL,
        SHR,
        PASS_R
    } alu_mode_t;

    // Jump conditions, bit 4 marks a jump
    typedef enum logic [4:0] {
        NONE   = 5'b00000,
        UNCOND = 5'b10000,
        CARRY  = 5'b10001,
        EQUAL  = 5'b10010,
        LT     = 5'b10011,
        GT     = 5'b10100,
        LE     = 5'b10101,
        GE     = 5'b10110,
        NE     = 5'b10111,
        OVF    = 5'b11000,
        PAR    = 5'b11001
    } jump_cond_t;

    localparam int JUMP_EN_BIT = 4;

    // Bit positions in the flag word
    typedef enum logic [2:0] {
        C = 3'd0,
        Z = 3'd1,
        N = 3'd2,
        O = 3'd3,
        P = 3'd4
    } flag_idx_e;

    typedef enum logic [`RW-1:0] {
        SREG_PC        = `SREG_PC_ADDR,
        SREG_PRIV_CTRL = `SREG_PRIV_CTRL_ADDR,
        SREG_IRQ_PC    = `SREG_IRQ_PC_ADDR,
        SREG_ALU_FLAGS = `SREG_ALU_FLAGS_ADDR
    } sreg_addr_t;

    // Privilege/control bits
    localparam int PRIV_MODE   = 0;
    localparam int PRIV_IRQ_EN = 2;

endpackage

//--- hw/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath word width
`define RW 16

// General register file size
`define REGNO 8
`define REGNO_LOG 3

// Number of ALU flags
`define FLAG_W 5

// PC value on interrupt entry
`define IRQ_VECTOR 16'h0010

// Special register addresses
`define SREG_PC_ADDR 16'h0000
`define SREG_PRIV_CTRL_ADDR 16'h0001
`define SREG_IRQ_PC_ADDR 16'h0003
`define SREG_ALU_FLAGS_ADDR 16'h0004

// Privilege/control value after reset, privileged with interrupts off
`define PRIV_CTRL_RESET 16'h0001

`endif

//--- hw/exec_alu.sv
`include "cpu_settings.svh"

module exec_alu (
    input  logic [`RW-1:0]     i_l,
    input  logic [`RW-1:0]     i_r,
    input  cpu_pkg::alu_mode_t i_mode,
    input  logic               i_carry,
    output logic [`RW-1:0]     o_out,
    output logic [`FLAG_W-1:0] o_flags
);

    localparam int SHW = $clog2(`RW);
    localparam int MSB = `RW - 1;

    // One extra bit on top catches carry or borrow
    logic [`RW:0] wide;
    logic         ovf;

    always_comb begin
        wide = '0;
        ovf = 1'b0;
        case (i_mode)
            cpu_pkg::ADD: begin
                wide = {1'b0, i_l} + {1'b0, i_r} + i_carry;
                ovf = (i_l[MSB] == i_r[MSB]) && (wide[MSB] != i_l[MSB]);
            end
            cpu_pkg::SUB: begin
                wide = {1'b0, i_l} - {1'b0, i_r} - i_carry;
                ovf = (i_l[MSB] != i_r[MSB]) && (wide[MSB] != i_l[MSB]);
            end
            cpu_pkg::AND: wide = {1'b0, i_l & i_r};
            cpu_pkg::OR:  wide = {1'b0, i_l | i_r};
            cpu_pkg::XOR: wide = {1'b0, i_l ^ i_r};
            cpu_pkg::SHL: wide = {1'b0, i_l << i_r[SHW-1:0]};
            cpu_pkg::SHR: wide = {1'b0, i_l >> i_r[SHW-1:0]};
            default: wide = {1'b0, i_r};
        endcase
    end

    assign o_out = wide[`RW-1:0];

    // Top bit stays zero for logic ops and shifts
    assign o_flags[cpu_pkg::C] = wide[`RW];
    assign o_flags[cpu_pkg::Z] = ~|o_out;
    assign o_flags[cpu_pkg::N] = o_out[MSB];
    assign o_flags[cpu_pkg::O] = ovf;
    // Set when the result has an even number of ones
    assign o_flags[cpu_pkg::P] = ~^o_out;

endmodule

//--- hw/exec_pc.sv
`include "cpu_settings.svh"

module exec_pc (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_inc,
    input  logic           i_load,
    input  logic           i_irq,
    input  logic [`RW-1:0] i_bus,
    output logic [`RW-1:0] o_pc
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else if (i_irq) begin
            o_pc <= `IRQ_VECTOR;
        end else if (i_load) begin
            o_pc <= i_bus;
        end else if (i_inc) begin
            o_pc <= o_pc + 1'b1;
        end
    end

    // Decode never asks for a step and a jump in the same instruction
    a_inc_load_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_inc && i_load));

endmodule

//--- hw/exec_regfile.sv
`include "cpu_settings.svh"

module exec_regfile (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [`REGNO_LOG-1:0] i_lsel,
    input  logic [`REGNO_LOG-1:0] i_rsel,
    input  logic [`REGNO-1:0]     i_ie,
    input  logic [`RW-1:0]        i_d,
    output logic [`RW-1:0]        o_l,
    output logic [`RW-1:0]        o_r
);

    logic [`RW-1:0] regs [`REGNO];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `REGNO; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REGNO; i++) begin
                if (i_ie[i]) begin
                    regs[i] <= i_d;
                end
            end
        end
    end

    // Asynchronous read ports
    assign o_l = regs[i_lsel];
    assign o_r = regs[i_rsel];

    // Writeback stage retires at most one register per cycle
    a_ie_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(i_ie));

endmodule

//--- hw/exec_sreg.sv
`include "cpu_settings.svh"

module exec_sreg (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic [`RW-1:0]     i_addr,
    input  logic [`RW-1:0]     i_wdata,
    input  logic               i_store,
    input  logic               i_irt,
    input  logic               i_irq_entry,
    input  logic [`RW-1:0]     i_pc,
    input  logic [`FLAG_W-1:0] i_flags,
    output logic [`RW-1:0]     o_rdata,
    output logic               o_irq_en,
    output logic               o_flags_we,
    output logic               o_pc_we
);

    logic [`RW-1:0] priv_ctrl;
    logic [`RW-1:0] irq_pc;
    logic           priv_mode;

    assign priv_mode = priv_ctrl[cpu_pkg::PRIV_MODE];
    assign o_irq_en = priv_ctrl[cpu_pkg::PRIV_IRQ_EN];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            priv_ctrl <= `PRIV_CTRL_RESET;
        end else if (i_irq_entry) begin
            // No nesting, handler runs with interrupts off
            priv_ctrl[cpu_pkg::PRIV_IRQ_EN] <= 1'b0;
        end else if (i_irt) begin
            priv_ctrl[cpu_pkg::PRIV_IRQ_EN] <= 1'b1;
        end else if (i_store && i_addr == cpu_pkg::SREG_PRIV_CTRL && priv_mode) begin
            priv_ctrl <= i_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_irq_entry) begin
            irq_pc <= i_pc;
        end else if (i_store && i_addr == cpu_pkg::SREG_IRQ_PC) begin
            irq_pc <= i_wdata;
        end
    end

    // Read mux, return from interrupt always sees the saved PC
    always_comb begin
        if (i_irt) begin
            o_rdata = irq_pc;
        end else begin
            case (i_addr)
                cpu_pkg::SREG_PC:        o_rdata = i_pc;
                cpu_pkg::SREG_PRIV_CTRL: o_rdata = priv_ctrl;
                cpu_pkg::SREG_IRQ_PC:    o_rdata = irq_pc;
                cpu_pkg::SREG_ALU_FLAGS: o_rdata = {{(`RW-`FLAG_W){1'b0}}, i_flags};
                default:                 o_rdata = '0;
            endcase
        end
    end

    // Flags and PC live outside, just report the store
    assign o_flags_we = i_store && (i_addr == cpu_pkg::SREG_ALU_FLAGS);
    assign o_pc_we = i_store && (i_addr == cpu_pkg::SREG_PC);

endmodule

//--- hw/execute.sv
`include "cpu_settings.svh"

module execute (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_submit,
    input  logic                  i_flush,
    input  logic                  i_jmp_predict,
    input  logic                  i_next_ready,
    input  logic [`RW-1:0]        i_imm,
    input  logic                  i_pc_inc,
    input  logic                  i_r_bus_imm,
    input  logic                  i_alu_carry_en,
    input  logic                  i_alu_flags_ie,
    input  logic                  i_mem_access,
    input  logic                  i_mem_we,
    input  logic                  i_mem_width,
    input  logic                  i_sreg_load,
    input  logic                  i_sreg_store,
    input  logic                  i_sreg_irt,
    input  logic                  i_sys,
    input  logic                  i_irq,
    input  cpu_pkg::alu_mode_t    i_alu_mode,
    input  logic [`REGNO_LOG-1:0] i_l_reg_sel,
    input  logic [`REGNO_LOG-1:0] i_r_reg_sel,
    input  logic [`REGNO-1:0]     i_rf_ie,
    input  logic [`REGNO-1:0]     i_reg_ie,
    input  cpu_pkg::jump_cond_t   i_jump_cond,
    input  logic [1:0]            i_used_operands,
    input  logic [`RW-1:0]        i_reg_data,
    output logic                  o_ready,
    output logic                  o_flush,
    output logic                  o_pc_update,
    output logic [`RW-1:0]        o_exec_pc,
    output logic [`RW-1:0]        o_data,
    output logic [`RW-1:0]        o_addr,
    output logic [`REGNO-1:0]     o_reg_ie,
    output logic                  o_mem_access,
    output logic                  o_mem_we,
    output logic                  o_mem_width,
    output logic                  o_submit
);

    logic [`REGNO-1:0]  pending;
    logic               hazard;
    logic               hold_valid;
    logic               sys_d;
    logic               irq;
    logic               irq_en;
    logic               invalidate;
    logic               in_valid;
    logic               instr_valid;
    logic               exec_submit;
    logic [`RW-1:0]     rf_l;
    logic [`RW-1:0]     rf_r;
    logic [`RW-1:0]     reg_l;
    logic [`RW-1:0]     reg_r;
    logic [`RW-1:0]     alu_out;
    logic [`FLAG_W-1:0] alu_flags;
    logic [`FLAG_W-1:0] flags_q;
    logic [`RW-1:0]     pc;
    logic [`RW-1:0]     pc_bus;
    logic [`RW-1:0]     sreg_rdata;
    logic               flags_we;
    logic               pc_we;
    logic               irt_q;
    logic               jump_valid;
    logic               jump_taken;
    logic               mispredict;

    // Operand still waiting for writeback, unless it lands this cycle
    assign hazard =
        (i_used_operands[0] && pending[i_l_reg_sel] && !i_reg_ie[i_l_reg_sel]) ||
        (i_used_operands[1] && pending[i_r_reg_sel] && !i_reg_ie[i_r_reg_sel]);

    // Interrupt entry kills the instruction in flight so it reruns after return
    assign irq = (i_irq && irq_en) || sys_d;
    assign invalidate = i_flush || irq;
    assign in_valid = i_submit && !invalidate;
    assign instr_valid = in_valid || (hold_valid && !i_submit && !invalidate);
    assign exec_submit = i_next_ready && instr_valid && !hazard;
    assign o_ready = exec_submit || !instr_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hold_valid <= 1'b0;
        end else if (invalidate || exec_submit) begin
            hold_valid <= 1'b0;
        end else if (in_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~i_reg_ie) | (exec_submit ? i_rf_ie : '0);
        end
    end

    // Sys enters the handler one cycle late, so the PC already points past it
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sys_d <= 1'b0;
        end else begin
            sys_d <= i_sys && exec_submit;
        end
    end

    exec_regfile u_regfile (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_lsel (i_l_reg_sel),
        .i_rsel (i_r_reg_sel),
        .i_ie   (i_reg_ie),
        .i_d    (i_reg_data),
        .o_l    (rf_l),
        .o_r    (rf_r)
    );

    // Bypass the value being written back this cycle
    assign reg_l = i_reg_ie[i_l_reg_sel] ? i_reg_data : rf_l;
    assign reg_r = i_reg_ie[i_r_reg_sel] ? i_reg_data : rf_r;

    exec_alu u_alu (
        .i_l     (reg_l),
        .i_r     (i_r_bus_imm ? i_imm : reg_r),
        .i_mode  (i_alu_mode),
        .i_carry (flags_q[cpu_pkg::C] && i_alu_carry_en),
        .o_out   (alu_out),
        .o_flags (alu_flags)
    );

    assign irt_q = i_sreg_irt && exec_submit;

    exec_sreg u_sreg (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_addr      (i_imm),
        .i_wdata     (reg_r),
        .i_store     (i_sreg_store && exec_submit),
        .i_irt       (irt_q),
        .i_irq_entry (irq),
        .i_pc        (pc),
        .i_flags     (flags_q),
        .o_rdata     (sreg_rdata),
        .o_irq_en    (irq_en),
        .o_flags_we  (flags_we),
        .o_pc_we     (pc_we)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q <= '0;
        end else if (flags_we) begin
            flags_q <= reg_r[`FLAG_W-1:0];
        end else if (i_alu_flags_ie && exec_submit) begin
            flags_q <= alu_flags;
        end
    end

    // Jump decode from the stored flags
    assign jump_valid = i_jump_cond[cpu_pkg::JUMP_EN_BIT];

    always_comb begin
        case (i_jump_cond)
            cpu_pkg::UNCOND: jump_taken = 1'b1;
            cpu_pkg::CARRY:  jump_taken = flags_q[cpu_pkg::C];
            cpu_pkg::EQUAL:  jump_taken = flags_q[cpu_pkg::Z];
            cpu_pkg::LT:     jump_taken = flags_q[cpu_pkg::N];
            cpu_pkg::GT:     jump_taken = !(flags_q[cpu_pkg::N] || flags_q[cpu_pkg::Z]);
            cpu_pkg::LE:     jump_taken = flags_q[cpu_pkg::N] || flags_q[cpu_pkg::Z];
            cpu_pkg::GE:     jump_taken = !flags_q[cpu_pkg::N];
            cpu_pkg::NE:     jump_taken = !flags_q[cpu_pkg::Z];
            cpu_pkg::OVF:    jump_taken = flags_q[cpu_pkg::O];
            cpu_pkg::PAR:    jump_taken = flags_q[cpu_pkg::P];
            default:         jump_taken = 1'b0;
        endcase
    end

    assign mispredict = jump_valid && (jump_taken != i_jmp_predict);

    // Return uses the saved PC, a store uses the register, a jump the ALU target
    assign pc_bus = irt_q ? sreg_rdata : (pc_we ? reg_r : alu_out);

    exec_pc u_pc (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_inc  ((i_pc_inc || (jump_valid && !jump_taken)) && exec_submit),
        .i_load (((jump_valid && jump_taken) && exec_submit) || pc_we || irt_q),
        .i_irq  (irq),
        .i_bus  (pc_bus),
        .o_pc   (pc)
    );

    assign o_pc_update = exec_submit;
    assign o_exec_pc = pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= (mispredict && exec_submit) || pc_we || irt_q || irq;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_submit <= 1'b0;
        end else begin
            o_submit <= exec_submit;
        end
    end

    always_ff @(posedge i_clk) begin
        if (exec_submit) begin
            o_addr <= alu_out;
            if (i_mem_access) begin
                o_data <= reg_r;
            end else if (i_sreg_load) begin
                o_data <= sreg_rdata;
            end else begin
                o_data <= alu_out;
            end
            o_reg_ie <= i_rf_ie;
            o_mem_access <= i_mem_access;
            o_mem_we <= i_mem_we;
            o_mem_width <= i_mem_width;
        end
    end

    // Writeback retires only registers issued earlier
    a_wb_pending: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_reg_ie & ~pending) == '0);

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_execute -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

//--- tb/tb_execute.sv
`include "cpu_settings.svh"

module tb_execute;

    logic                  i_clk = 1'b0;
    logic                  i_rst;
    logic                  i_submit;
    logic                  i_flush;
    logic                  i_jmp_predict;
    logic                  i_next_ready;
    logic [`RW-1:0]        i_imm;
    logic                  i_pc_inc;
    logic                  i_r_bus_imm;
    logic                  i_alu_carry_en;
    logic                  i_alu_flags_ie;
    logic                  i_mem_access;
    logic                  i_mem_we;
    logic                  i_mem_width;
    logic                  i_sreg_load;
    logic                  i_sreg_store;
    logic                  i_sreg_irt;
    logic                  i_sys;
    logic                  i_irq;
    cpu_pkg::alu_mode_t    i_alu_mode;
    logic [`REGNO_LOG-1:0] i_l_reg_sel;
    logic [`REGNO_LOG-1:0] i_r_reg_sel;
    logic [`REGNO-1:0]     i_rf_ie;
    logic [`REGNO-1:0]     i_reg_ie = '0;
    cpu_pkg::jump_cond_t   i_jump_cond;
    logic [1:0]            i_used_operands;
    logic [`RW-1:0]        i_reg_data = '0;
    logic                  o_ready;
    logic                  o_flush;
    logic                  o_pc_update;
    logic [`RW-1:0]        o_exec_pc;
    logic [`RW-1:0]        o_data;
    logic [`RW-1:0]        o_addr;
    logic [`REGNO-1:0]     o_reg_ie;
    logic                  o_mem_access;
    logic                  o_mem_we;
    logic                  o_mem_width;
    logic                  o_submit;

    // Reference state built from the architecture rules
    logic [`RW-1:0] regs_m [`REGNO];
    logic [4:0]     flags_m;
    logic [`RW-1:0] pc_m;
    int             test_errs;
    int             tests_passed;
    int             tests_failed;

    always #10 i_clk = ~i_clk;

    execute uut (.*);

    // Writeback stage model returns register results one cycle later
    always @(posedge i_clk) begin
        if (o_submit === 1'b1 && !o_mem_access) begin
            i_reg_ie <= o_reg_ie;
            i_reg_data <= o_data;
        end else begin
            i_reg_ie <= '0;
        end
    end

    function automatic logic [`RW-1:0] alu_model(input cpu_pkg::alu_mode_t mode,
                                                 input logic [`RW-1:0] l,
                                                 input logic [`RW-1:0] r,
                                                 output logic [4:0] f);
        logic [`RW:0] w;
        logic         ov;
        ov = 1'b0;
        case (mode)
            cpu_pkg::ADD: begin
                w = {1'b0, l} + {1'b0, r};
                ov = (l[15] == r[15]) && (w[15] != l[15]);
            end
            cpu_pkg::SUB: begin
                w = {1'b0, l} - {1'b0, r};
                ov = (l[15] != r[15]) && (w[15] != l[15]);
            end
            cpu_pkg::AND: w = {1'b0, l & r};
            cpu_pkg::OR:  w = {1'b0, l | r};
            cpu_pkg::XOR: w = {1'b0, l ^ r};
            cpu_pkg::SHL: w = {1'b0, l << r[3:0]};
            cpu_pkg::SHR: w = {1'b0, l >> r[3:0]};
            default:      w = {1'b0, r};
        endcase
        f = {~^w[15:0], ov, w[15], w[15:0] == 16'h0000, w[16]};
        return w[15:0];
    endfunction

    function automatic logic cond_taken(input cpu_pkg::jump_cond_t c, input logic [4:0] f);
        case (c)
            cpu_pkg::UNCOND: return 1'b1;
            cpu_pkg::CARRY:  return f[0];
            cpu_pkg::EQUAL:  return f[1];
            cpu_pkg::LT:     return f[2];
            cpu_pkg::GT:     return !(f[2] || f[1]);
            cpu_pkg::LE:     return f[2] || f[1];
            cpu_pkg::GE:     return !f[2];
            cpu_pkg::NE:     return !f[1];
            cpu_pkg::OVF:    return f[3];
            cpu_pkg::PAR:    return f[4];
            default:         return 1'b0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [`RW-1:0] got,
                             input logic [`RW-1:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("%s: ok", name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic set_defaults();
        @(posedge i_clk);
        i_flush <= 1'b0;
        i_jmp_predict <= 1'b0;
        i_next_ready <= 1'b1;
        i_imm <= '0;
        i_pc_inc <= 1'b0;
        i_r_bus_imm <= 1'b1;
        i_alu_carry_en <= 1'b0;
        i_alu_flags_ie <= 1'b0;
        i_mem_access <= 1'b0;
        i_mem_we <= 1'b0;
        i_mem_width <= 1'b0;
        i_sreg_load <= 1'b0;
        i_sreg_store <= 1'b0;
        i_sreg_irt <= 1'b0;
        i_sys <= 1'b0;
        i_irq <= 1'b0;
        i_alu_mode <= cpu_pkg::PASS_R;
        i_l_reg_sel <= '0;
        i_r_reg_sel <= '0;
        i_rf_ie <= '0;
        i_jump_cond <= cpu_pkg::NONE;
        i_used_operands <= 2'b00;
    endtask

    // Present the instruction and wait until the stage takes it
    task automatic wait_accept();
        int n;
        n = 0;
        i_submit <= 1'b1;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_ready && n < 50);
        assert (o_ready) else begin
            $display("Timeout waiting for the stage to accept an instruction");
            test_errs++;
        end
        check_val("o_pc_update", o_pc_update, 1'b1);
    endtask

    task automatic finish_instr(input logic exp_flush);
        @(posedge i_clk);
        i_submit <= 1'b0;
        @(negedge i_clk);
        check_val("o_submit", o_submit, 1'b1);
        check_val("o_flush", o_flush, exp_flush);
        check_val("o_exec_pc", o_exec_pc, pc_m);
    endtask

    task automatic alu_op(input cpu_pkg::alu_mode_t mode, input int dst, input int ls,
                          input int rs, input logic use_imm, input logic [`RW-1:0] imm,
                          input logic set_flags);
        logic [`RW-1:0] res;
        logic [4:0]     f;
        res = alu_model(mode, regs_m[ls], use_imm ? imm : regs_m[rs], f);
        set_defaults();
        i_alu_mode <= mode;
        i_l_reg_sel <= ls[2:0];
        i_r_reg_sel <= rs[2:0];
        i_r_bus_imm <= use_imm;
        i_imm <= imm;
        i_used_operands <= use_imm ? 2'b01 : 2'b11;
        i_rf_ie <= 8'(1) << dst;
        i_alu_flags_ie <= set_flags;
        i_pc_inc <= 1'b1;
        wait_accept();
        pc_m = pc_m + 16'd1;
        finish_instr(1'b0);
        check_val("o_data", o_data, res);
        check_val("o_reg_ie", o_reg_ie, 16'(1) << dst);
        regs_m[dst] = res;
        if (set_flags) begin
            flags_m = f;
        end
    endtask

    task automatic sreg_read(input logic [`RW-1:0] addr, input logic [`RW-1:0] exp);
        set_defaults();
        i_sreg_load <= 1'b1;
        i_imm <= addr;
        i_pc_inc <= 1'b1;
        wait_accept();
        pc_m = pc_m + 16'd1;
        finish_instr(1'b0);
        check_val("o_data", o_data, exp);
    endtask

    task automatic jump_op(input cpu_pkg::jump_cond_t c, input logic predict,
                           input logic [`RW-1:0] target);
        logic taken;
        taken = cond_taken(c, flags_m);
        set_defaults();
        i_jump_cond <= c;
        i_alu_mode <= cpu_pkg::ADD;
        i_imm <= target;
        i_used_operands <= 2'b01;
        i_jmp_predict <= predict;
        wait_accept();
        pc_m = taken ? target : pc_m + 16'd1;
        finish_instr(taken != predict);
    endtask

    task automatic irq_pulse();
        @(posedge i_clk);
        i_irq <= 1'b1;
        @(posedge i_clk);
        i_irq <= 1'b0;
        @(negedge i_clk);
    endtask

    task automatic alu_results();
        alu_op(cpu_pkg::PASS_R, 1, 0, 0, 1'b1, 16'h1234, 1'b0);
        alu_op(cpu_pkg::PASS_R, 2, 0, 0, 1'b1, 16'h0F0F, 1'b0);
        alu_op(cpu_pkg::ADD, 3, 1, 2, 1'b0, 16'h0000, 1'b1);
        alu_op(cpu_pkg::SUB, 4, 2, 1, 1'b0, 16'h0000, 1'b1);
        sreg_read(16'h0004, {11'd0, flags_m});
        alu_op(cpu_pkg::XOR, 5, 1, 2, 1'b0, 16'h0000, 1'b1);
        alu_op(cpu_pkg::SHL, 6, 1, 0, 1'b1, 16'h0004, 1'b1);
        sreg_read(16'h0004, {11'd0, flags_m});
        end_test("alu");
    endtask

    task automatic jump_conditions();
        cpu_pkg::jump_cond_t conds [10];
        conds = '{cpu_pkg::UNCOND, cpu_pkg::CARRY, cpu_pkg::EQUAL, cpu_pkg::LT,
                  cpu_pkg::GT, cpu_pkg::LE, cpu_pkg::GE, cpu_pkg::NE,
                  cpu_pkg::OVF, cpu_pkg::PAR};
        // Positive and then negative compare results
        for (int s = 0; s < 2; s++) begin
            alu_op(cpu_pkg::SUB, 4, s ? 2 : 1, s ? 1 : 2, 1'b0, 16'h0000, 1'b1);
            for (int i = 0; i < 10; i++) begin
                jump_op(conds[i], cond_taken(conds[i], flags_m) ^ i[0],
                        16'h0040 + 16'(s * 16 + i));
            end
        end
        end_test("jumps");
    endtask

    task automatic read_after_write();
        set_defaults();
        i_imm <= 16'h00AA;
        i_rf_ie <= 8'h80;
        i_pc_inc <= 1'b1;
        i_used_operands <= 2'b01;
        wait_accept();
        pc_m = pc_m + 16'd1;
        @(posedge i_clk);
        // Next instruction reads r7 right behind its producer
        i_alu_mode <= cpu_pkg::ADD;
        i_l_reg_sel <= 3'd7;
        i_imm <= 16'h0001;
        i_rf_ie <= 8'h08;
        @(negedge i_clk);
        check_val("o_ready", o_ready, 1'b0);
        check_val("o_submit", o_submit, 1'b1);
        check_val("o_data", o_data, 16'h00AA);
        wait_accept();
        pc_m = pc_m + 16'd1;
        finish_instr(1'b0);
        check_val("o_data", o_data, 16'h00AB);
        regs_m[7] = 16'h00AA;
        regs_m[3] = 16'h00AB;
        end_test("hazard");
    endtask

    task automatic back_pressure();
        logic [`RW-1:0] val;
        int             len;
        for (int k = 0; k < 4; k++) begin
            val = 16'($urandom);
            len = 1 + int'($urandom % 5);
            set_defaults();
            i_next_ready <= 1'b0;
            i_imm <= val;
            i_rf_ie <= 8'h40;
            i_pc_inc <= 1'b1;
            i_submit <= 1'b1;
            repeat (len) begin
                @(negedge i_clk);
                check_val("o_submit", o_submit, 1'b0);
                check_val("o_ready", o_ready, 1'b0);
                check_val("o_pc_update", o_pc_update, 1'b0);
            end
            @(posedge i_clk);
            i_next_ready <= 1'b1;
            wait_accept();
            pc_m = pc_m + 16'd1;
            finish_instr(1'b0);
            check_val("o_data", o_data, val);
            regs_m[6] = val;
            @(negedge i_clk);
            check_val("o_submit", o_submit, 1'b0);
        end
        end_test("backpressure");
    endtask

    task automatic mem_op(input logic we, input logic width, input logic [`RW-1:0] imm);
        set_defaults();
        i_mem_access <= 1'b1;
        i_mem_we <= we;
        i_mem_width <= width;
        i_alu_mode <= cpu_pkg::ADD;
        i_l_reg_sel <= 3'd1;
        i_r_reg_sel <= 3'd2;
        i_imm <= imm;
        i_used_operands <= we ? 2'b11 : 2'b01;
        i_pc_inc <= 1'b1;
        wait_accept();
        pc_m = pc_m + 16'd1;
        finish_instr(1'b0);
        check_val("o_addr", o_addr, regs_m[1] + imm);
        check_val("o_mem_access", o_mem_access, 1'b1);
        check_val("o_mem_we", o_mem_we, we);
        check_val("o_mem_width", o_mem_width, width);
        if (we) begin
            check_val("o_data", o_data, regs_m[2]);
        end
    endtask

    task automatic memory_access();
        mem_op(1'b1, 1'b1, 16'h0020);
        mem_op(1'b0, 1'b0, 16'h0008);
        end_test("memory");
    endtask

    task automatic interrupt_flow();
        logic [`RW-1:0] saved;
        alu_op(cpu_pkg::PASS_R, 4, 0, 0, 1'b1, 16'h0001 | (16'h0001 << cpu_pkg::PRIV_IRQ_EN),
               1'b0);
        set_defaults();
        i_sreg_store <= 1'b1;
        i_imm <= 16'h0001;
        i_r_reg_sel <= 3'd4;
        i_used_operands <= 2'b10;
        i_pc_inc <= 1'b1;
        wait_accept();
        pc_m = pc_m + 16'd1;
        finish_instr(1'b0);
        irq_pulse();
        saved = pc_m;
        pc_m = `IRQ_VECTOR;
        check_val("o_flush", o_flush, 1'b1);
        check_val("o_exec_pc", o_exec_pc, pc_m);
        // Handler runs with interrupts off
        irq_pulse();
        check_val("o_flush", o_flush, 1'b0);
        check_val("o_exec_pc", o_exec_pc, pc_m);
        sreg_read(16'h0003, saved);
        set_defaults();
        i_sreg_irt <= 1'b1;
        wait_accept();
        pc_m = saved;
        finish_instr(1'b1);
        set_defaults();
        i_sys <= 1'b1;
        i_pc_inc <= 1'b1;
        wait_accept();
        pc_m = pc_m + 16'd1;
        finish_instr(1'b0);
        saved = pc_m;
        @(negedge i_clk);
        pc_m = `IRQ_VECTOR;
        check_val("o_flush", o_flush, 1'b1);
        check_val("o_exec_pc", o_exec_pc, pc_m);
        sreg_read(16'h0003, saved);
        end_test("interrupts");
    endtask

    initial begin
        i_rst <= 1'b1;
        i_submit <= 1'b0;
        i_flush <= 1'b0;
        i_jmp_predict <= 1'b0;
        i_next_ready <= 1'b1;
        i_imm <= '0;
        i_pc_inc <= 1'b0;
        i_r_bus_imm <= 1'b0;
        i_alu_carry_en <= 1'b0;
        i_alu_flags_ie <= 1'b0;
        i_mem_access <= 1'b0;
        i_mem_we <= 1'b0;
        i_mem_width <= 1'b0;
        i_sreg_load <= 1'b0;
        i_sreg_store <= 1'b0;
        i_sreg_irt <= 1'b0;
        i_sys <= 1'b0;
        i_irq <= 1'b0;
        i_alu_mode <= cpu_pkg::PASS_R;
        i_l_reg_sel <= '0;
        i_r_reg_sel <= '0;
        i_rf_ie <= '0;
        i_jump_cond <= cpu_pkg::NONE;
        i_used_operands <= 2'b00;
        void'($urandom(37));
        for (int i = 0; i < `REGNO; i++) begin
            regs_m[i] = '0;
        end
        flags_m = '0;
        pc_m = '0;
        test_errs = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;
        alu_results();
        jump_conditions();
        read_after_write();
        back_pressure();
        memory_access();
        interrupt_flow();
        $display("passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/cpu_pkg.sv
hw/exec_alu.sv
hw/exec_regfile.sv
hw/exec_pc.sv
hw/exec_sreg.sv
hw/execute.sv
tb/tb_execute.sv
